// ==== hw/sparc_decode_pkg.sv ====
`default_nettype none

package sparc_decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [1:0]  fmt_t;
    typedef logic [5:0]  op3_t;
    typedef logic [2:0]  op2_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  mem_size_t;
    typedef logic [3:0]  raw_bits_t;    // {i31, i30, i24, i13}

    // instruction format, bits 31:30
    localparam fmt_t fmt_branch = 2'b00;
    localparam fmt_t fmt_call   = 2'b01;
    localparam fmt_t fmt_arith  = 2'b10;
    localparam fmt_t fmt_mem    = 2'b11;

    // op2 under format 00
    localparam op2_t op2_sethi = 3'b100;
    localparam op2_t op2_bicc  = 3'b010;

    localparam mem_size_t size_byte = 2'd0;
    localparam mem_size_t size_half = 2'd1;
    localparam mem_size_t size_word = 2'd2;

    // loads and stores, format 11
    localparam op3_t op3_ld   = 6'b000000;
    localparam op3_t op3_ldub = 6'b000001;
    localparam op3_t op3_lduh = 6'b000010;
    localparam op3_t op3_ldsb = 6'b001001;
    localparam op3_t op3_ldsh = 6'b001010;
    localparam op3_t op3_st   = 6'b000100;
    localparam op3_t op3_stb  = 6'b000101;
    localparam op3_t op3_sth  = 6'b000110;

    // control transfer and window ops, format 10
    localparam op3_t op3_jmpl    = 6'b111000;
    localparam op3_t op3_save    = 6'b111100;
    localparam op3_t op3_restore = 6'b111101;

    // arithmetic, logic and shifts, format 10
    localparam op3_t op3_add    = 6'b000000;
    localparam op3_t op3_addcc  = 6'b010000;
    localparam op3_t op3_addx   = 6'b001000;
    localparam op3_t op3_addxcc = 6'b011000;
    localparam op3_t op3_sub    = 6'b000100;
    localparam op3_t op3_subcc  = 6'b010100;
    localparam op3_t op3_subx   = 6'b001100;
    localparam op3_t op3_and    = 6'b000001;
    localparam op3_t op3_andcc  = 6'b010001;
    localparam op3_t op3_andn   = 6'b000101;
    localparam op3_t op3_andncc = 6'b010101;
    localparam op3_t op3_or     = 6'b000010;
    localparam op3_t op3_orcc   = 6'b010010;
    localparam op3_t op3_orn    = 6'b000110;
    localparam op3_t op3_orncc  = 6'b010110;
    localparam op3_t op3_xor    = 6'b000011;
    localparam op3_t op3_xorcc  = 6'b010011;
    localparam op3_t op3_xnor   = 6'b000111;
    localparam op3_t op3_xnorcc = 6'b010111;
    localparam op3_t op3_sll    = 6'b100101;
    localparam op3_t op3_srl    = 6'b100110;
    localparam op3_t op3_sra    = 6'b100111;

    localparam alu_op_t alu_add    = 4'd0;
    localparam alu_op_t alu_addx   = 4'd1;
    localparam alu_op_t alu_sub    = 4'd2;
    localparam alu_op_t alu_subx   = 4'd3;
    localparam alu_op_t alu_and    = 4'd4;
    localparam alu_op_t alu_or     = 4'd5;
    localparam alu_op_t alu_xor    = 4'd6;
    localparam alu_op_t alu_xnor   = 4'd7;
    localparam alu_op_t alu_andn   = 4'd8;
    localparam alu_op_t alu_orn    = 4'd9;
    localparam alu_op_t alu_sll    = 4'd10;
    localparam alu_op_t alu_srl    = 4'd11;
    localparam alu_op_t alu_sra    = 4'd12;
    localparam alu_op_t alu_pass_b = 4'd14;    // sethi, operand b straight through

endpackage

`default_nettype wire

// ==== hw/mem_decoder.sv ====
`default_nettype none

module mem_decoder import sparc_decode_pkg::*; (
    input  op3_t      op3,
    output logic      load,
    output logic      mem_se,
    output logic      mem_rw,
    output mem_size_t mem_size,
    output logic      mem_enable
);

    always_comb begin
        // unlisted op3 leaves everything low
        load       = 1'b0;
        mem_se     = 1'b0;
        mem_rw     = 1'b0;
        mem_size   = size_byte;
        mem_enable = 1'b0;

        case (op3)
            op3_ldsb: begin
                load       = 1'b1;
                mem_se     = 1'b1;
                mem_size   = size_byte;
                mem_enable = 1'b1;
            end
            op3_ldsh: begin
                load       = 1'b1;
                mem_se     = 1'b1;
                mem_size   = size_half;
                mem_enable = 1'b1;
            end
            op3_ld: begin
                load       = 1'b1;
                mem_size   = size_word;
                mem_enable = 1'b1;
            end
            op3_ldub: begin
                load       = 1'b1;       // zero extended
                mem_size   = size_byte;
                mem_enable = 1'b1;
            end
            op3_lduh: begin
                load       = 1'b1;
                mem_size   = size_half;
                mem_enable = 1'b1;
            end
            // stores put the memory in write mode
            op3_stb: begin
                mem_rw     = 1'b1;
                mem_size   = size_byte;
                mem_enable = 1'b1;
            end
            op3_sth: begin
                mem_rw     = 1'b1;
                mem_size   = size_half;
                mem_enable = 1'b1;
            end
            op3_st: begin
                mem_rw     = 1'b1;
                mem_size   = size_word;
                mem_enable = 1'b1;
            end
            default: begin
                mem_enable = 1'b0;
            end
        endcase
    end

    // a read and a write on one access would fight over the data bus
    always_comb begin
        a_no_load_store: assert (!(load && mem_rw))
            else $error("mem_decoder: load and write both set for op3 %b", op3);
    end

endmodule

`default_nettype wire

// ==== hw/arith_decoder.sv ====
`default_nettype none

module arith_decoder import sparc_decode_pkg::*; (
    input  op3_t      op3,
    output logic      jmpl,
    output logic      rf_enable,
    output logic      mem_enable,
    output mem_size_t mem_size,
    output alu_op_t   alu_op,
    output logic      cc_enable
);

    always_comb begin
        jmpl       = 1'b0;
        rf_enable  = 1'b0;
        mem_enable = 1'b0;
        mem_size   = size_byte;
        alu_op     = alu_add;
        cc_enable  = 1'b0;

        case (op3)
            op3_jmpl: jmpl = 1'b1;

            // register window shift, word access
            op3_save, op3_restore: begin
                rf_enable  = 1'b1;
                mem_enable = 1'b1;
                mem_size   = size_word;
            end

            op3_add:    alu_op = alu_add;
            op3_addcc: begin
                alu_op    = alu_add;
                cc_enable = 1'b1;
            end
            op3_addx:   alu_op = alu_addx;    // add with carry
            op3_addxcc: begin
                alu_op    = alu_addx;
                cc_enable = 1'b1;
            end
            op3_sub:    alu_op = alu_sub;
            op3_subcc: begin
                alu_op    = alu_sub;
                cc_enable = 1'b1;
            end
            op3_subx:   alu_op = alu_subx;    // no cc variant decoded
            op3_and:    alu_op = alu_and;
            op3_andcc: begin
                alu_op    = alu_and;
                cc_enable = 1'b1;
            end
            op3_andn:   alu_op = alu_andn;
            op3_andncc: begin
                alu_op    = alu_andn;
                cc_enable = 1'b1;
            end
            op3_or:     alu_op = alu_or;
            op3_orcc: begin
                alu_op    = alu_or;
                cc_enable = 1'b1;
            end
            op3_orn:    alu_op = alu_orn;
            op3_orncc: begin
                alu_op    = alu_orn;
                cc_enable = 1'b1;
            end
            op3_xor:    alu_op = alu_xor;
            op3_xorcc: begin
                alu_op    = alu_xor;
                cc_enable = 1'b1;
            end
            op3_xnor:   alu_op = alu_xnor;
            op3_xnorcc: begin
                alu_op    = alu_xnor;
                cc_enable = 1'b1;
            end

            // shifts never touch the condition codes
            op3_sll: alu_op = alu_sll;
            op3_srl: alu_op = alu_srl;
            op3_sra: alu_op = alu_sra;

            default: alu_op = alu_add;
        endcase
    end

    always_comb begin
        if (cc_enable) begin
            a_cc_alu: assert (alu_op inside {alu_add, alu_addx, alu_sub, alu_and, alu_andn,
                                             alu_or, alu_orn, alu_xor, alu_xnor})
                else $error("arith_decoder: cc_enable with alu_op %0d", alu_op);
        end
    end

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`default_nettype none

module instr_decoder import sparc_decode_pkg::*; (
    input  instr_t    instr,
    output logic      jmpl,
    output logic      call,
    output logic      branch,
    output logic      load,
    output logic      rf_enable,
    output logic      mem_se,
    output logic      mem_rw,
    output logic      mem_enable,
    output mem_size_t mem_size,
    output alu_op_t   alu_op,
    output logic      cc_enable,
    output raw_bits_t raw_bits
);

    fmt_t      fmt;
    op2_t      op2;
    op3_t      op3;

    // op 11 side
    logic      md_load;
    logic      md_mem_se;
    logic      md_mem_rw;
    mem_size_t md_mem_size;
    logic      md_mem_enable;

    // op 10 side
    logic      ad_jmpl;
    logic      ad_rf_enable;
    logic      ad_mem_enable;
    mem_size_t ad_mem_size;
    alu_op_t   ad_alu_op;
    logic      ad_cc_enable;

    assign fmt      = instr[31:30];
    assign op2      = instr[24:22];
    assign op3      = instr[24:19];
    assign raw_bits = {instr[31], instr[30], instr[24], instr[13]};    // passes even for nop

    mem_decoder i_mem_decoder (
        .op3        (op3),
        .load       (md_load),
        .mem_se     (md_mem_se),
        .mem_rw     (md_mem_rw),
        .mem_size   (md_mem_size),
        .mem_enable (md_mem_enable)
    );

    arith_decoder i_arith_decoder (
        .op3        (op3),
        .jmpl       (ad_jmpl),
        .rf_enable  (ad_rf_enable),
        .mem_enable (ad_mem_enable),
        .mem_size   (ad_mem_size),
        .alu_op     (ad_alu_op),
        .cc_enable  (ad_cc_enable)
    );

    always_comb begin
        jmpl       = 1'b0;
        call       = 1'b0;
        branch     = 1'b0;
        load       = 1'b0;
        rf_enable  = 1'b0;
        mem_se     = 1'b0;
        mem_rw     = 1'b0;
        mem_enable = 1'b0;
        mem_size   = size_byte;
        alu_op     = alu_add;
        cc_enable  = 1'b0;

        if (instr != '0) begin    // all zero is a nop
            case (fmt)
                fmt_branch: begin
                    if (op2 == op2_sethi) alu_op = alu_pass_b;
                    else if (op2 == op2_bicc) branch = 1'b1;
                end
                fmt_call: begin
                    call      = 1'b1;
                    rf_enable = 1'b1;    // return address into o7
                end
                fmt_arith: begin
                    jmpl       = ad_jmpl;
                    rf_enable  = ad_rf_enable;
                    mem_enable = ad_mem_enable;
                    mem_size   = ad_mem_size;
                    alu_op     = ad_alu_op;
                    cc_enable  = ad_cc_enable;
                end
                fmt_mem: begin
                    load       = md_load;
                    mem_se     = md_mem_se;
                    mem_rw     = md_mem_rw;
                    mem_size   = md_mem_size;
                    mem_enable = md_mem_enable;
                    rf_enable  = md_mem_enable;    // only for a recognised opcode
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage import sparc_decode_pkg::*; (
    input  logic      clk,
    input  logic      clr,
    // decoded word, not yet registered
    input  logic      dec_jmpl,
    input  logic      dec_call,
    input  logic      dec_branch,
    input  logic      dec_load,
    input  logic      dec_rf_enable,
    input  logic      dec_mem_se,
    input  logic      dec_mem_rw,
    input  logic      dec_mem_enable,
    input  mem_size_t dec_mem_size,
    input  alu_op_t   dec_alu_op,
    input  logic      dec_cc_enable,
    input  raw_bits_t dec_raw_bits,
    input  logic      instr_valid,
    output logic      instr_ready,
    input  logic      bubble,
    input  logic      out_ready,
    output logic      out_valid,
    output logic      jmpl,
    output logic      call,
    output logic      branch,
    output logic      load,
    output logic      rf_enable,
    output logic      mem_se,
    output logic      mem_rw,
    output logic      mem_enable,
    output mem_size_t mem_size,
    output alu_op_t   alu_op,
    output logic      cc_enable,
    output raw_bits_t raw_bits
);

    logic      accept;
    logic      jmpl_q, call_q, branch_q, load_q, rf_enable_q;
    logic      mem_se_q, mem_rw_q, mem_enable_q, cc_enable_q;
    mem_size_t mem_size_q;
    alu_op_t   alu_op_q;
    raw_bits_t raw_bits_q;

    // single slot, refilled on the same edge it drains
    assign instr_ready = !out_valid || out_ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk or negedge clr) begin
        if (!clr) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge clr) begin
        if (!clr) begin
            {jmpl_q, call_q, branch_q, load_q, rf_enable_q} <= '0;
            {mem_se_q, mem_rw_q, mem_enable_q, cc_enable_q} <= '0;
            mem_size_q <= size_byte;
            alu_op_q   <= alu_add;
            raw_bits_q <= '0;
        end else if (accept) begin
            jmpl_q       <= dec_jmpl;
            call_q       <= dec_call;
            branch_q     <= dec_branch;
            load_q       <= dec_load;
            rf_enable_q  <= dec_rf_enable;
            mem_se_q     <= dec_mem_se;
            mem_rw_q     <= dec_mem_rw;
            mem_enable_q <= dec_mem_enable;
            mem_size_q   <= dec_mem_size;
            alu_op_q     <= dec_alu_op;
            cc_enable_q  <= dec_cc_enable;
            raw_bits_q   <= dec_raw_bits;
        end
    end

    // hazard bubble squashes the offered word, handshake untouched
    assign jmpl       = bubble ? 1'b0 : jmpl_q;
    assign call       = bubble ? 1'b0 : call_q;
    assign branch     = bubble ? 1'b0 : branch_q;
    assign load       = bubble ? 1'b0 : load_q;
    assign rf_enable  = bubble ? 1'b0 : rf_enable_q;
    assign mem_se     = bubble ? 1'b0 : mem_se_q;
    assign mem_rw     = bubble ? 1'b0 : mem_rw_q;
    assign mem_enable = bubble ? 1'b0 : mem_enable_q;
    assign mem_size   = bubble ? size_byte : mem_size_q;
    assign alu_op     = bubble ? alu_add : alu_op_q;
    assign cc_enable  = bubble ? 1'b0 : cc_enable_q;
    assign raw_bits   = bubble ? '0 : raw_bits_q;

    // a stalled word must still be there, unchanged, on the next edge
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!clr)
        out_valid && !out_ready |=> out_valid && $stable({jmpl_q, call_q, branch_q, load_q,
            rf_enable_q, mem_se_q, mem_rw_q, mem_enable_q, mem_size_q, alu_op_q,
            cc_enable_q, raw_bits_q}))
        else $error("decode_stage: word changed under back-pressure");

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`default_nettype none

module control_unit import sparc_decode_pkg::*; (
    input  logic      clk,
    input  logic      clr,
    input  instr_t    instr,
    input  logic      instr_valid,
    output logic      instr_ready,
    input  logic      bubble,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      jmpl,
    output logic      call,
    output logic      branch,
    output logic      load,
    output logic      rf_enable,
    output logic      mem_se,
    output logic      mem_rw,
    output logic      mem_enable,
    output mem_size_t mem_size,
    output alu_op_t   alu_op,
    output logic      cc_enable,
    output raw_bits_t raw_bits
);

    logic      dec_jmpl, dec_call, dec_branch, dec_load, dec_rf_enable;
    logic      dec_mem_se, dec_mem_rw, dec_mem_enable, dec_cc_enable;
    mem_size_t dec_mem_size;
    alu_op_t   dec_alu_op;
    raw_bits_t dec_raw_bits;

    instr_decoder i_instr_decoder (
        .instr      (instr),
        .jmpl       (dec_jmpl),
        .call       (dec_call),
        .branch     (dec_branch),
        .load       (dec_load),
        .rf_enable  (dec_rf_enable),
        .mem_se     (dec_mem_se),
        .mem_rw     (dec_mem_rw),
        .mem_enable (dec_mem_enable),
        .mem_size   (dec_mem_size),
        .alu_op     (dec_alu_op),
        .cc_enable  (dec_cc_enable),
        .raw_bits   (dec_raw_bits)
    );

    decode_stage i_decode_stage (
        .clk            (clk),
        .clr            (clr),
        .dec_jmpl       (dec_jmpl),
        .dec_call       (dec_call),
        .dec_branch     (dec_branch),
        .dec_load       (dec_load),
        .dec_rf_enable  (dec_rf_enable),
        .dec_mem_se     (dec_mem_se),
        .dec_mem_rw     (dec_mem_rw),
        .dec_mem_enable (dec_mem_enable),
        .dec_mem_size   (dec_mem_size),
        .dec_alu_op     (dec_alu_op),
        .dec_cc_enable  (dec_cc_enable),
        .dec_raw_bits   (dec_raw_bits),
        .instr_valid    (instr_valid),
        .instr_ready    (instr_ready),
        .bubble         (bubble),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .jmpl           (jmpl),
        .call           (call),
        .branch         (branch),
        .load           (load),
        .rf_enable      (rf_enable),
        .mem_se         (mem_se),
        .mem_rw         (mem_rw),
        .mem_enable     (mem_enable),
        .mem_size       (mem_size),
        .alu_op         (alu_op),
        .cc_enable      (cc_enable),
        .raw_bits       (raw_bits)
    );

endmodule

`default_nettype wire

// ==== tb/control_unit_model.svh ====
`ifndef CONTROL_UNIT_MODEL_SVH
`define CONTROL_UNIT_MODEL_SVH

// expected control word, one field per DUT output
typedef struct packed {
    logic       jmpl;
    logic       call;
    logic       branch;
    logic       load;
    logic       rf_enable;
    logic       mem_se;
    logic       mem_rw;
    logic       mem_enable;
    logic [1:0] mem_size;
    logic [3:0] alu_op;
    logic       cc_enable;
    logic [3:0] raw_bits;
} ctrl_word_t;

function automatic ctrl_word_t expected_word(input logic [31:0] ins);
    ctrl_word_t w;
    logic [5:0] op3;
    logic       alu_hit;
    logic [3:0] alu_code;
    logic [4:0] mem_bits;    // {load, se, rw, size}
    w = '0;
    op3 = ins[24:19];
    w.raw_bits = {ins[31], ins[30], ins[24], ins[13]};

    // low nibble selects the operation, bit 4 selects the cc variant
    alu_hit = 1'b1;
    case (op3[3:0])
        4'b0000: alu_code = 4'd0;     // add
        4'b1000: alu_code = 4'd1;     // addx
        4'b0100: alu_code = 4'd2;     // sub
        4'b1100: alu_code = 4'd3;     // subx
        4'b0001: alu_code = 4'd4;     // and
        4'b0010: alu_code = 4'd5;     // or
        4'b0011: alu_code = 4'd6;     // xor
        4'b0111: alu_code = 4'd7;     // xnor
        4'b0101: alu_code = 4'd8;     // andn
        4'b0110: alu_code = 4'd9;     // orn
        default: alu_code = 4'd0;
    endcase
    if (op3[5] || op3 == 6'b011100 || !(op3[3:0] inside {4'b0000, 4'b1000, 4'b0100,
            4'b1100, 4'b0001, 4'b0010, 4'b0011, 4'b0111, 4'b0101, 4'b0110}))
        alu_hit = 1'b0;    // subxcc not in the table

    if (ins != 32'h0) begin
        case (ins[31:30])
            2'b00: begin
                if (ins[24:22] == 3'b100)
                    w.alu_op = 4'd14;
                else if (ins[24:22] == 3'b010)
                    w.branch = 1'b1;
            end
            2'b01: begin
                w.call      = 1'b1;
                w.rf_enable = 1'b1;
            end
            2'b10: begin
                if (alu_hit) begin
                    w.alu_op    = alu_code;
                    w.cc_enable = op3[4];
                end else begin
                    case (op3)
                        6'b111000: w.jmpl = 1'b1;
                        6'b111100, 6'b111101: begin
                            w.rf_enable  = 1'b1;
                            w.mem_enable = 1'b1;
                            w.mem_size   = 2'd2;
                        end
                        6'b100101: w.alu_op = 4'd10;
                        6'b100110: w.alu_op = 4'd11;
                        6'b100111: w.alu_op = 4'd12;
                        default: w.alu_op = 4'd0;
                    endcase
                end
            end
            default: begin
                w.mem_enable = 1'b1;
                case (op3)
                    6'b001001: mem_bits = 5'b110_00;    // ldsb
                    6'b001010: mem_bits = 5'b110_01;    // ldsh
                    6'b000000: mem_bits = 5'b100_10;    // ld
                    6'b000001: mem_bits = 5'b100_00;    // ldub
                    6'b000010: mem_bits = 5'b100_01;    // lduh
                    6'b000101: mem_bits = 5'b001_00;    // stb
                    6'b000110: mem_bits = 5'b001_01;    // sth
                    6'b000100: mem_bits = 5'b001_10;    // st
                    default: begin
                        mem_bits     = 5'b000_00;
                        w.mem_enable = 1'b0;
                    end
                endcase
                {w.load, w.mem_se, w.mem_rw, w.mem_size} = mem_bits;
                w.rf_enable = w.mem_enable;
            end
        endcase
    end
    return w;
endfunction

`endif

// ==== tb/tb_control_unit.sv ====
`default_nettype none

module tb_control_unit import sparc_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_instr        = 2000;
    localparam int timeout_cycles = 10 * n_instr;

    logic      clk;
    logic      clr;
    instr_t    instr;
    logic      instr_valid;
    logic      instr_ready;
    logic      bubble;
    logic      out_valid;
    logic      out_ready;
    logic      jmpl, call, branch, load, rf_enable;
    logic      mem_se, mem_rw, mem_enable, cc_enable;
    mem_size_t mem_size;
    alu_op_t   alu_op;
    raw_bits_t raw_bits;

    `include "control_unit_model.svh"

    instr_t     stim[$];
    ctrl_word_t exp_q[$];    // one entry per word in flight
    int         next_idx;
    int         delivered;
    int         cycle_count;
    logic       in_xfer;
    logic       was_stalled;

    op3_t arith_ops[25] = '{op3_jmpl, op3_save, op3_restore, op3_add, op3_addcc, op3_addx,
        op3_addxcc, op3_sub, op3_subcc, op3_subx, op3_and, op3_andcc, op3_andn, op3_andncc,
        op3_or, op3_orcc, op3_orn, op3_orncc, op3_xor, op3_xorcc, op3_xnor, op3_xnorcc,
        op3_sll, op3_srl, op3_sra};
    op3_t mem_ops[8] = '{op3_ld, op3_ldub, op3_lduh, op3_ldsb, op3_ldsh,
        op3_st, op3_stb, op3_sth};

    control_unit i_dut (
        .clk         (clk),
        .clr         (clr),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .bubble      (bubble),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .jmpl        (jmpl),
        .call        (call),
        .branch      (branch),
        .load        (load),
        .rf_enable   (rf_enable),
        .mem_se      (mem_se),
        .mem_rw      (mem_rw),
        .mem_enable  (mem_enable),
        .mem_size    (mem_size),
        .alu_op      (alu_op),
        .cc_enable   (cc_enable),
        .raw_bits    (raw_bits)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic compare_word(input ctrl_word_t exp);
        check_value("jmpl", 32'(jmpl), 32'(exp.jmpl));
        check_value("call", 32'(call), 32'(exp.call));
        check_value("branch", 32'(branch), 32'(exp.branch));
        check_value("load", 32'(load), 32'(exp.load));
        check_value("rf_enable", 32'(rf_enable), 32'(exp.rf_enable));
        check_value("mem_se", 32'(mem_se), 32'(exp.mem_se));
        check_value("mem_rw", 32'(mem_rw), 32'(exp.mem_rw));
        check_value("mem_enable", 32'(mem_enable), 32'(exp.mem_enable));
        check_value("mem_size", 32'(mem_size), 32'(exp.mem_size));
        check_value("alu_op", 32'(alu_op), 32'(exp.alu_op));
        check_value("cc_enable", 32'(cc_enable), 32'(exp.cc_enable));
        check_value("raw_bits", 32'(raw_bits), 32'(exp.raw_bits));
    endtask

    // random word with a chosen format and op3
    function automatic instr_t with_op3(input fmt_t fmt, input op3_t op3);
        instr_t w;
        w = $urandom;
        w[31:30] = fmt;
        w[24:19] = op3;
        return w;
    endfunction

    function automatic instr_t branch_format(input op2_t op2);
        instr_t w;
        w = $urandom;
        w[31:30] = fmt_branch;
        w[24:22] = op2;
        return w;
    endfunction

    function automatic instr_t call_format();
        instr_t w;
        w = $urandom;
        w[31:30] = fmt_call;
        return w;
    endfunction

    function automatic instr_t random_instr();
        int unsigned pick;
        pick = $urandom_range(0, 9);
        case (pick)
            0: return '0;    // nop
            1, 2, 3: return with_op3(fmt_arith, arith_ops[$urandom_range(0, 24)]);
            4, 5: return with_op3(fmt_mem, mem_ops[$urandom_range(0, 7)]);
            6: return branch_format($urandom_range(0, 1) ? op2_sethi : op2_bicc);
            7: return call_format();
            default: return $urandom;
        endcase
    endfunction

    task automatic build_stimulus();
        foreach (arith_ops[i]) stim.push_back(with_op3(fmt_arith, arith_ops[i]));
        foreach (mem_ops[i]) stim.push_back(with_op3(fmt_mem, mem_ops[i]));
        // op3 values outside both tables
        stim.push_back(with_op3(fmt_mem, 6'b111111));
        stim.push_back(with_op3(fmt_mem, 6'b000011));
        stim.push_back(with_op3(fmt_arith, 6'b011100));    // subxcc
        stim.push_back(with_op3(fmt_arith, 6'b110101));
        stim.push_back('0);
        stim.push_back(branch_format(op2_sethi));
        stim.push_back(branch_format(op2_bicc));
        stim.push_back(branch_format(3'b000));
        stim.push_back(call_format());
        while (stim.size() < n_instr)
            stim.push_back(random_instr());
    endtask

    task automatic drive_inputs();
        if (in_xfer)
            next_idx++;
        instr_valid = (next_idx < stim.size()) && ($urandom_range(0, 9) < 7);
        instr       = instr_valid ? stim[next_idx] : instr_t'($urandom);
        out_ready   = ($urandom_range(0, 3) != 0);
        bubble      = ($urandom_range(0, 7) == 0);
    endtask

    // sampled mid-cycle while inputs and outputs are settled
    task automatic monitor_cycle();
        logic       out_xfer;
        ctrl_word_t head;
        out_xfer = out_valid && out_ready;
        in_xfer  = instr_valid && instr_ready;
        if (was_stalled)
            check_value("out_valid", 32'(out_valid), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'(exp_q.size() != 0));
        check_value("instr_ready", 32'(instr_ready), 32'(exp_q.size() == 0 || out_ready));
        if (out_valid) begin
            if (bubble)
                head = '0;
            else
                head = exp_q[0];
            compare_word(head);
        end
        if (out_xfer) begin
            void'(exp_q.pop_front());
            delivered++;
        end
        if (in_xfer)
            exp_q.push_back(expected_word(instr));
        was_stalled = out_valid && !out_ready;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: control words stopped arriving after %0d cycles, %0d of %0d out",
                 cycle_count, delivered, n_instr);
        abort_run();
    end

    initial begin
        clr         = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        bubble      = 1'b0;
        out_ready   = 1'b0;
        in_xfer     = 1'b0;
        was_stalled = 1'b0;
        next_idx    = 0;
        delivered   = 0;
        void'($urandom(32'h760b_d4ea));
        build_stimulus();

        repeat (10) @(posedge clk);
        #1;
        clr = 1'b1;

        // idle state straight after reset
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("instr_ready", 32'(instr_ready), 32'd1);
        compare_word('0);

        while (delivered < n_instr) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            monitor_cycle();
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tb
hw/sparc_decode_pkg.sv
hw/mem_decoder.sv
hw/arith_decoder.sv
hw/instr_decoder.sv
hw/decode_stage.sv
hw/control_unit.sv
tb/tb_control_unit.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_control_unit
FILELIST   = files.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
